// ==== hdl/cart_defines.svh ====
`default_nettype none
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

// bus widths
`define CART_ADDR_W        24           // snes / host byte address
`define CART_SRAM_AW       20           // sram word address per chip

// sequencer slots
`define CART_SLOTS         12           // slots per full sequence
`define CART_SNES_SLOTS    6            // first host slot

// config reset values
`define CART_ROM_MASK_RST  24'hff_ffff  // whole rom visible
`define CART_SAVE_MASK_RST 24'h00_1fff  // 8 KiB save ram
`define CART_SAVE_BASE     24'h60_0000  // save ram byte base in sram

`endif
`default_nettype wire

// ==== hdl/cart_pkg.sv ====
`include "cart_defines.svh"
`default_nettype none

package cart_pkg;

   // memory map flavour
   typedef enum logic {
      MAP_HIROM = 1'b0,
      MAP_LOROM = 1'b1
   } mapper_e;

   // upper nibble of a host command byte
   typedef enum logic [3:0] {
      CMD_MAPPER    = 4'h1,   // mapper in low nibble
      CMD_ADDR      = 4'h2,   // 3 param bytes, msb first
      CMD_ROM_MASK  = 4'h3,
      CMD_SAVE_MASK = 4'h4,
      CMD_READ      = 4'h8,   // one sram read per param strobe
      CMD_WRITE     = 4'h9    // param byte goes to sram
   } host_cmd_e;

   typedef struct packed {
      mapper_e                 mapper;
      logic [`CART_ADDR_W-1:0] rom_mask;
      logic [`CART_ADDR_W-1:0] save_mask;
   } map_cfg_t;

   typedef struct packed {
      logic snes_cap;     // grab snes write byte
      logic snes_lat;     // sram read byte for snes
      logic host_lat;     // sram read byte for host
      logic drive_sram;   // sram data bus enable
      logic host_phase;   // host owns the address
   } dp_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/host_if.sv ====
`timescale 1ns/1ps
`include "cart_defines.svh"
`default_nettype none

// host access channel between command regs, sequencer, map and data path
// a request level stays up until the sequencer pulses done
interface host_if;
   logic                    rd_req;   // sram read pending
   logic                    wr_req;   // sram write pending
   logic [`CART_ADDR_W-1:0] addr;     // host pointer, bumps after each byte
   logic [7:0]              wdata;    // byte to write
   logic [7:0]              rdata;    // last byte read for host
   logic                    done;     // single clk2 pulse in slot 11

   modport regs (output rd_req, wr_req, addr, wdata, input done);

   modport seq (input rd_req, wr_req, output done);

   modport map (input addr);

   modport dp (input wdata, output rdata);

endinterface

`default_nettype wire

// ==== hdl/host_regs.sv ====
`timescale 1ns/1ps
`include "cart_defines.svh"
`default_nettype none

module host_regs
   import cart_pkg::*;
(
   input  logic       clk2,
   input  logic       rst_n,
   input  logic       cmd_strobe,
   input  logic       param_strobe,
   input  logic [7:0] cmd_byte,
   output logic       host_busy,
   output map_cfg_t   cfg,
   host_if.regs       hif
);

   host_cmd_e  cmd;         // last accepted command
   logic [1:0] pcnt;        // param bytes taken so far
   logic       busy;
   logic       take_cmd;
   logic       take_param;
   logic       shift_ok;

   assign busy       = hif.rd_req | hif.wr_req;   // access in flight
   assign host_busy  = busy;
   assign take_cmd   = cmd_strobe & ~busy;        // strobes dropped while busy
   assign take_param = param_strobe & ~busy;
   assign shift_ok   = (pcnt != 2'd3);            // 24 bit params only

   ////////////////////////////////////////
   // command decode and config registers
   ////////////////////////////////////////
   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         cmd           <= CMD_MAPPER;
         pcnt          <= 2'd0;
         cfg.mapper    <= MAP_HIROM;
         cfg.rom_mask  <= `CART_ROM_MASK_RST;
         cfg.save_mask <= `CART_SAVE_MASK_RST;
         hif.addr      <= '0;
         hif.rd_req    <= 1'b0;
         hif.wr_req    <= 1'b0;
      end else begin
         if (hif.done) begin
            hif.rd_req <= 1'b0;
            hif.wr_req <= 1'b0;
            hif.addr   <= hif.addr + 24'd1;   // stream pointer
         end
         if (take_cmd) begin
            cmd  <= host_cmd_e'(cmd_byte[7:4]);
            pcnt <= 2'd0;
            if (cmd_byte[7:4] == CMD_MAPPER)
               cfg.mapper <= mapper_e'(cmd_byte[0]);
         end else if (take_param) begin
            if (shift_ok)
               pcnt <= pcnt + 2'd1;
            case (cmd)
               CMD_ADDR: begin
                  if (shift_ok)
                     hif.addr <= {hif.addr[15:0], cmd_byte};   // msb first
               end
               CMD_ROM_MASK: begin
                  if (shift_ok)
                     cfg.rom_mask <= {cfg.rom_mask[15:0], cmd_byte};
               end
               CMD_SAVE_MASK: begin
                  if (shift_ok)
                     cfg.save_mask <= {cfg.save_mask[15:0], cmd_byte};
               end
               CMD_READ:  hif.rd_req <= 1'b1;
               CMD_WRITE: hif.wr_req <= 1'b1;
               default: ;                             // mapper has no params
            endcase
         end
      end
   end

   // write byte, held until the host half drives it
   always_ff @(posedge clk2) begin
      if (take_param && cmd == CMD_WRITE)
         hif.wdata <= cmd_byte;
   end

endmodule

`default_nettype wire

// ==== hdl/addr_map.sv ====
`timescale 1ns/1ps
`include "cart_defines.svh"
`default_nettype none

module addr_map
   import cart_pkg::*;
(
   input  logic [`CART_ADDR_W-1:0]  snes_addr,
   input  map_cfg_t                 cfg,
   input  dp_ctrl_t                 ctrl,
   host_if.map                      hif,
   output logic [`CART_SRAM_AW-1:0] sram_addr,
   output logic [3:0]               sram_ce_n,
   output logic                     byte_sel,
   output logic                     is_rom,
   output logic                     is_saveram
);

   logic                    hi_save;     // hirom save window hit
   logic                    lo_save;     // lorom save window hit
   logic [`CART_ADDR_W-1:0] rom_off;
   logic [`CART_ADDR_W-1:0] save_off;
   logic [`CART_ADDR_W-1:0] byte_addr;   // final sram byte address

   // banks 20 to 3f and a0 to bf, offsets 6000 to 7fff
   assign hi_save = (snes_addr[22:21] == 2'b01) && (snes_addr[15:13] == 3'b011);
   // banks 70 to 7d below 8000
   assign lo_save = (snes_addr[23:20] == 4'h7) && (snes_addr[19:16] < 4'he)
                    && !snes_addr[15];

   always_comb begin
      if (cfg.mapper == MAP_HIROM) begin
         is_saveram = hi_save;
         is_rom     = (snes_addr[22] | snes_addr[15]) & ~hi_save;
         rom_off    = {2'b00, snes_addr[21:0]};                      // linear 4M
         save_off   = {6'd0, snes_addr[20:16], snes_addr[12:0]};     // 8K per bank
      end else begin
         is_saveram = lo_save;
         is_rom     = snes_addr[15];                                 // upper half only
         rom_off    = {2'b00, snes_addr[22:16], snes_addr[14:0]};    // 32K pages
         save_off   = {5'd0, snes_addr[19:16], snes_addr[14:0]};
      end
   end

   always_comb begin
      if (ctrl.host_phase)
         byte_addr = hif.addr;                                  // host takes it raw
      else if (is_saveram)
         byte_addr = `CART_SAVE_BASE + (save_off & cfg.save_mask);
      else
         byte_addr = rom_off & cfg.rom_mask;
   end

   assign sram_addr = byte_addr[20:1];                   // 16 bit words
   assign byte_sel  = byte_addr[0];                      // 1 = upper lane
   assign sram_ce_n = (ctrl.host_phase | is_rom | is_saveram)
                      ? ~(4'b0001 << byte_addr[22:21])   // one of four chips
                      : 4'b1111;                         // address hits no region

endmodule

`default_nettype wire

// ==== hdl/cycle_seq.sv ====
`timescale 1ns/1ps
`include "cart_defines.svh"
`default_nettype none

module cycle_seq
   import cart_pkg::*;
(
   input  logic     clk2,
   input  logic     rst_n,
   input  logic     snes_rd_n,
   input  logic     snes_wr_n,
   input  logic     is_saveram,
   input  logic     byte_sel,
   host_if.seq      hif,
   output dp_ctrl_t ctrl,
   output logic     sram_oe_n,
   output logic     sram_we_n,
   output logic     sram_bhe_n,
   output logic     sram_ble_n
);

   localparam logic [3:0] SLOT_HOST = 4'(`CART_SNES_SLOTS);   // 6
   localparam logic [3:0] SLOT_LAST = 4'(`CART_SLOTS - 1);    // 11
   localparam logic [3:0] SLOT_IDLE = 4'(`CART_SLOTS);        // parked

   logic [1:0] rd_sync;
   logic [1:0] wr_sync;
   logic       rw_now;      // synced rd & wr
   logic       rw_prev;
   logic       start;       // falling edge, new snes cycle
   logic [3:0] slot;
   logic       snes_rd;     // kind taken at start
   logic       snes_wr;
   logic       host_rd;     // kind taken when host half granted
   logic       host_wr;
   logic       host_req;
   logic       in_snes;
   logic       in_host;
   logic       oe_act;
   logic       we_act;

   ////////////////////////////////////////
   // strobe sync and start detect
   ////////////////////////////////////////
   assign rw_now   = rd_sync[1] & wr_sync[1];
   assign start    = rw_prev & ~rw_now;
   assign host_req = hif.rd_req | hif.wr_req;

   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         rd_sync <= 2'b11;
         wr_sync <= 2'b11;
         rw_prev <= 1'b1;
      end else begin
         rd_sync <= {rd_sync[0], snes_rd_n};
         wr_sync <= {wr_sync[0], snes_wr_n};
         rw_prev <= rw_now;
      end
   end

   ////////////////////////////////////////
   // slot counter
   ////////////////////////////////////////
   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         slot    <= SLOT_IDLE;
         snes_rd <= 1'b0;
         snes_wr <= 1'b0;
         host_rd <= 1'b0;
         host_wr <= 1'b0;
      end else if (start) begin               // snes always wins, restart at 0
         slot    <= 4'd0;
         snes_rd <= ~rd_sync[1];
         snes_wr <= ~wr_sync[1] & rd_sync[1];
         host_rd <= 1'b0;                     // pending req rides the next host half
         host_wr <= 1'b0;
      end else if ((slot == SLOT_IDLE && host_req) || slot == SLOT_HOST - 4'd1) begin
         slot    <= SLOT_HOST;                // host half or host-only pass
         host_rd <= hif.rd_req;
         host_wr <= hif.wr_req;
      end else if (slot == SLOT_LAST || slot == SLOT_IDLE) begin
         slot <= SLOT_IDLE;
      end else begin
         slot <= slot + 4'd1;
      end
   end

   assign in_snes  = (slot < SLOT_HOST);
   assign in_host  = (host_rd | host_wr) && slot >= SLOT_HOST && slot <= SLOT_LAST;
   assign hif.done = in_host && (slot == SLOT_LAST);

   // per slot strobes
   always_comb begin
      ctrl   = '0;
      oe_act = 1'b0;
      we_act = 1'b0;
      if (in_snes) begin
         if (snes_rd) begin
            oe_act        = 1'b1;                  // whole snes half
            ctrl.snes_lat = (slot == 4'd4);
         end else if (snes_wr) begin
            ctrl.snes_cap   = (slot == 4'd2);
            we_act          = is_saveram && (slot == 4'd3 || slot == 4'd4);
            ctrl.drive_sram = is_saveram && slot >= 4'd3;   // hold past we rise
         end
      end else if (in_host) begin
         ctrl.host_phase = 1'b1;
         if (host_wr) begin
            we_act          = (slot == 4'd8 || slot == 4'd9);
            ctrl.drive_sram = slot >= 4'd7 && slot <= 4'd10;
         end else begin
            oe_act        = slot >= 4'd7 && slot <= 4'd10;
            ctrl.host_lat = (slot == 4'd10);
         end
      end
   end

   assign sram_oe_n  = ~oe_act;
   assign sram_we_n  = ~we_act;
   assign sram_ble_n = ~(oe_act | (we_act & ~byte_sel));   // reads take both lanes
   assign sram_bhe_n = ~(oe_act | (we_act & byte_sel));

endmodule

`default_nettype wire

// ==== hdl/data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_path
   import cart_pkg::*;
(
   input  logic        clk2,
   input  logic        rst_n,
   input  dp_ctrl_t    ctrl,
   input  logic        byte_sel,
   input  logic [7:0]  snes_data_in,
   input  logic [15:0] sram_data_in,
   output logic [7:0]  snes_data_out,
   output logic [15:0] sram_data_out,
   output logic        sram_data_oe,
   host_if.dp          hif
);

   logic [7:0] snes_wbyte;   // captured snes write data
   logic [7:0] wr_byte;
   logic [7:0] rd_byte;

   // lane pick on reads
   assign rd_byte = byte_sel ? sram_data_in[15:8] : sram_data_in[7:0];

   // same byte on both halves, bhe/ble choose the lane
   assign wr_byte       = ctrl.host_phase ? hif.wdata : snes_wbyte;
   assign sram_data_out = {wr_byte, wr_byte};
   assign sram_data_oe  = ctrl.drive_sram;

   always_ff @(posedge clk2) begin
      if (ctrl.snes_cap)
         snes_wbyte <= snes_data_in;
   end

   // read latches, held until the next read of that master
   always_ff @(posedge clk2 or negedge rst_n) begin
      if (!rst_n) begin
         snes_data_out <= 8'h00;
         hif.rdata     <= 8'h00;
      end else begin
         if (ctrl.snes_lat)
            snes_data_out <= rd_byte;
         if (ctrl.host_lat)
            hif.rdata <= rd_byte;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/cart_top.sv ====
`timescale 1ns/1ps
`include "cart_defines.svh"
`default_nettype none

module cart_top
   import cart_pkg::*;
(
   input  logic                     clk2,
   input  logic                     rst_n,
   // snes bus
   input  logic [`CART_ADDR_W-1:0]  snes_addr,
   input  logic                     snes_rd_n,
   input  logic                     snes_wr_n,
   input  logic                     snes_cs_n,
   input  logic [7:0]               snes_data_in,
   output logic [7:0]               snes_data_out,
   output logic                     snes_data_oe,
   // sram
   output logic [`CART_SRAM_AW-1:0] sram_addr,
   output logic [3:0]               sram_ce_n,
   output logic                     sram_oe_n,
   output logic                     sram_we_n,
   output logic                     sram_bhe_n,
   output logic                     sram_ble_n,
   input  logic [15:0]              sram_data_in,
   output logic [15:0]              sram_data_out,
   output logic                     sram_data_oe,
   // host byte port
   input  logic                     cmd_strobe,
   input  logic                     param_strobe,
   input  logic [7:0]               cmd_byte,
   output logic [7:0]               host_rdata,
   output logic                     host_busy
);

   host_if   hif ();
   map_cfg_t cfg;          // mapper and masks
   dp_ctrl_t ctrl;         // slot strobes
   logic     byte_sel;
   logic     is_rom;
   logic     is_saveram;

   host_regs u_host_regs (
      .clk2         (clk2),
      .rst_n        (rst_n),
      .cmd_strobe   (cmd_strobe),
      .param_strobe (param_strobe),
      .cmd_byte     (cmd_byte),
      .host_busy    (host_busy),
      .cfg          (cfg),
      .hif          (hif)
   );

   addr_map u_addr_map (
      .snes_addr  (snes_addr),
      .cfg        (cfg),
      .ctrl       (ctrl),
      .hif        (hif),
      .sram_addr  (sram_addr),
      .sram_ce_n  (sram_ce_n),
      .byte_sel   (byte_sel),
      .is_rom     (is_rom),
      .is_saveram (is_saveram)
   );

   cycle_seq u_cycle_seq (
      .clk2       (clk2),
      .rst_n      (rst_n),
      .snes_rd_n  (snes_rd_n),
      .snes_wr_n  (snes_wr_n),
      .is_saveram (is_saveram),
      .byte_sel   (byte_sel),
      .hif        (hif),
      .ctrl       (ctrl),
      .sram_oe_n  (sram_oe_n),
      .sram_we_n  (sram_we_n),
      .sram_bhe_n (sram_bhe_n),
      .sram_ble_n (sram_ble_n)
   );

   data_path u_data_path (
      .clk2          (clk2),
      .rst_n         (rst_n),
      .ctrl          (ctrl),
      .byte_sel      (byte_sel),
      .snes_data_in  (snes_data_in),
      .sram_data_in  (sram_data_in),
      .snes_data_out (snes_data_out),
      .sram_data_out (sram_data_out),
      .sram_data_oe  (sram_data_oe),
      .hif           (hif)
   );

   assign host_rdata = hif.rdata;

   // drive the snes bus only on reads we own, rom needs /cart
   assign snes_data_oe = ~snes_rd_n & (is_saveram | (is_rom & ~snes_cs_n));

endmodule

`default_nettype wire

// ==== testbench/tb_cart.sv ====
`timescale 1ns/1ps
`include "cart_defines.svh"
`default_nettype none

module tb_cart;

   localparam int HOST_OPS     = 210;     // strobes plus accesses over all tests
   localparam int SNES_OPS     = 40;
   localparam int TEST_CYCLES  = HOST_OPS * 40 + SNES_OPS * 20;
   localparam int IDLE_TIMEOUT = 200;     // cycles for one host access

   logic        clk2 = 1'b0;
   logic        rst_n;
   logic [23:0] snes_addr;
   logic        snes_rd_n;
   logic        snes_wr_n;
   logic        snes_cs_n;
   logic [7:0]  snes_data_in;
   logic [7:0]  snes_data_out;
   logic        snes_data_oe;
   logic [19:0] sram_addr;
   logic [3:0]  sram_ce_n;
   logic        sram_oe_n;
   logic        sram_we_n;
   logic        sram_bhe_n;
   logic        sram_ble_n;
   logic [15:0] sram_data_in;
   logic [15:0] sram_data_out;
   logic        sram_data_oe;
   logic        cmd_strobe;
   logic        param_strobe;
   logic [7:0]  cmd_byte;
   logic [7:0]  host_rdata;
   logic        host_busy;

   logic [15:0] sram_mem [0:4*1024*1024-1];   // 4 chips of 1M x 16
   logic [7:0]  ref_mem [0:8*1024*1024-1];    // by sram byte address
   logic [1:0]  chip;
   logic [21:0] wrd;
   logic        chip_on;

   integer      seed = 32'h6dd1_50e8;
   int          errs;
   int          checks;
   int          t_errs;
   int          t_checks;
   int          k;
   logic        cur_mapper;      // 0 hirom, 1 lorom
   logic [23:0] cur_rom_mask;
   logic [23:0] cur_save_mask;
   logic [23:0] host_ptr;       // model of the auto increment pointer
   logic [23:0] base [0:5];
   logic [7:0]  hbytes [0:15];
   logic [23:0] a;
   logic [23:0] sa;
   logic [31:0] r;
   logic [31:0] rh;
   logic [31:0] rs;
   logic [7:0]  lo;
   logic [7:0]  hi;
   logic        sv;
   logic        rm;

   cart_top u_cart_top (
      .clk2          (clk2),
      .rst_n         (rst_n),
      .snes_addr     (snes_addr),
      .snes_rd_n     (snes_rd_n),
      .snes_wr_n     (snes_wr_n),
      .snes_cs_n     (snes_cs_n),
      .snes_data_in  (snes_data_in),
      .snes_data_out (snes_data_out),
      .snes_data_oe  (snes_data_oe),
      .sram_addr     (sram_addr),
      .sram_ce_n     (sram_ce_n),
      .sram_oe_n     (sram_oe_n),
      .sram_we_n     (sram_we_n),
      .sram_bhe_n    (sram_bhe_n),
      .sram_ble_n    (sram_ble_n),
      .sram_data_in  (sram_data_in),
      .sram_data_out (sram_data_out),
      .sram_data_oe  (sram_data_oe),
      .cmd_strobe    (cmd_strobe),
      .param_strobe  (param_strobe),
      .cmd_byte      (cmd_byte),
      .host_rdata    (host_rdata),
      .host_busy     (host_busy)
   );

   always #20 clk2 = ~clk2;   // 40 ns

   ////////////////////////////////////////
   // sram model of four async chips
   ////////////////////////////////////////
   always_comb begin
      case (sram_ce_n)
         4'b1101: chip = 2'd1;
         4'b1011: chip = 2'd2;
         4'b0111: chip = 2'd3;
         default: chip = 2'd0;
      endcase
   end

   assign chip_on      = (sram_ce_n != 4'b1111);   // some chip enabled
   assign wrd          = {chip, sram_addr};
   assign sram_data_in = (!sram_oe_n && chip_on) ? sram_mem[wrd] : 16'h0000;

   // write mid cycle when controls have settled since the rising edge
   always @(negedge clk2) begin
      if (!sram_we_n && sram_data_oe && chip_on) begin
         if (!sram_ble_n)
            sram_mem[wrd][7:0] = sram_data_out[7:0];
         if (!sram_bhe_n)
            sram_mem[wrd][15:8] = sram_data_out[15:8];
      end
   end

   ////////////////////////////////////////
   // reference model helpers
   ////////////////////////////////////////
   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic logic [7:0] fill_byte(input logic [22:0] b);
      fill_byte = b[7:0] ^ b[15:8] ^ {1'b0, b[22:16]} ^ 8'h5a;   // whole address
   endfunction

   // snes address to sram byte address per memory map
   function automatic logic [23:0] map_snes(input logic [23:0] addr, output logic save,
                                            output logic rom);
      logic [7:0]  bank;
      logic [15:0] ofs;
      logic [23:0] off;
      bank = addr[23:16];
      ofs  = addr[15:0];
      if (cur_mapper == 1'b0) begin
         save = ((bank >= 8'h20 && bank <= 8'h3f) || (bank >= 8'ha0 && bank <= 8'hbf))
                && ofs >= 16'h6000 && ofs <= 16'h7fff;
         rom  = (addr[22] || addr[15]) && !save;
         off  = save ? 24'(bank[4:0]) * 24'h2000 + 24'(ofs - 16'h6000)   // 8K per bank
                     : addr & 24'h3f_ffff;
      end else begin
         save = bank >= 8'h70 && bank <= 8'h7d && ofs < 16'h8000;
         rom  = addr[15];
         off  = save ? 24'(bank - 8'h70) * 24'h8000 + 24'(ofs[14:0])
                     : 24'(addr[22:16]) * 24'h8000 + 24'(ofs[14:0]);   // 32K pages
      end
      if (save)
         map_snes = `CART_SAVE_BASE + (off & cur_save_mask);
      else
         map_snes = off & cur_rom_mask;
   endfunction

   task automatic check_byte(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
      checks++;
      t_checks++;
      assert (act === exp) else begin
         $display("** Error: %s expected %02h actual %02h", name, exp, act);
         errs++;
         t_errs++;
      end
   endtask

   task automatic start_test();
      t_errs   = 0;
      t_checks = 0;
   endtask

   task automatic end_test(input string name);
      $display("test %s done: %0d checks, %0d errors", name, t_checks, t_errs);
   endtask

   ////////////////////////////////////////
   // host port
   ////////////////////////////////////////
   task automatic strobe_cmd(input logic [7:0] b);
      @(posedge clk2);
      cmd_strobe <= 1'b1;
      cmd_byte   <= b;
      @(posedge clk2);
      cmd_strobe <= 1'b0;
   endtask

   task automatic strobe_param(input logic [7:0] b);
      @(posedge clk2);
      param_strobe <= 1'b1;
      cmd_byte     <= b;
      @(posedge clk2);
      param_strobe <= 1'b0;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      @(negedge clk2);
      while (host_busy && n < IDLE_TIMEOUT) begin
         @(negedge clk2);
         n++;
      end
      if (host_busy) begin
         $display("host access at %06h never finished", host_ptr);
         errs++;
         t_errs++;
      end
   endtask

   task automatic set_host_addr(input logic [23:0] addr);
      strobe_cmd(8'h20);
      strobe_param(addr[23:16]);   // high byte first
      strobe_param(addr[15:8]);
      strobe_param(addr[7:0]);
      host_ptr = addr;
   endtask

   task automatic set_mapper(input logic m);
      strobe_cmd({7'b0001_000, m});
      cur_mapper = m;
   endtask

   task automatic set_rom_mask(input logic [23:0] m);
      strobe_cmd(8'h30);
      strobe_param(m[23:16]);
      strobe_param(m[15:8]);
      strobe_param(m[7:0]);
      cur_rom_mask = m;
   endtask

   task automatic host_write(input logic [7:0] data);
      strobe_param(data);
      wait_idle();
      ref_mem[host_ptr[22:0]] = data;
      host_ptr = host_ptr + 24'd1;
   endtask

   task automatic host_read_check(input string name);
      strobe_param(8'h00);
      wait_idle();
      check_byte(name, ref_mem[host_ptr[22:0]], host_rdata);
      host_ptr = host_ptr + 24'd1;
   endtask

   ////////////////////////////////////////
   // snes bus
   ////////////////////////////////////////
   task automatic snes_read_check(input string name, input logic [23:0] addr);
      logic [23:0] ma;
      logic        save;
      logic        rom;
      ma = map_snes(addr, save, rom);
      @(posedge clk2);
      snes_addr <= addr;
      snes_cs_n <= 1'b0;
      snes_rd_n <= 1'b0;
      repeat (10) @(posedge clk2);   // data due within 10 cycles
      @(negedge clk2);
      check_byte(name, ref_mem[ma[22:0]], snes_data_out);
      check_byte({name, "_oe"}, {7'd0, save | rom}, {7'd0, snes_data_oe});
      @(posedge clk2);
      snes_rd_n <= 1'b1;
      snes_cs_n <= 1'b1;
      repeat (2 + next_rand() % 5) @(posedge clk2);   // random gap
   endtask

   task automatic snes_write(input logic [23:0] addr, input logic [7:0] data);
      logic [23:0] ma;
      logic        save;
      logic        rom;
      ma = map_snes(addr, save, rom);
      if (save)
         ref_mem[ma[22:0]] = data;   // rom never written by snes
      @(posedge clk2);
      snes_addr    <= addr;
      snes_data_in <= data;
      snes_wr_n    <= 1'b0;
      repeat (10) @(posedge clk2);
      snes_wr_n <= 1'b1;
      repeat (4) @(posedge clk2);
   endtask

   // watchdog at twice the estimated run
   initial begin
      #(TEST_CYCLES * 40 * 2);
      $display("watchdog expired, the run did not finish in time");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      rst_n        = 1'b0;
      snes_addr    = 24'h00_0000;
      snes_rd_n    = 1'b1;
      snes_wr_n    = 1'b1;
      snes_cs_n    = 1'b1;
      snes_data_in = 8'h00;
      cmd_strobe   = 1'b0;
      param_strobe = 1'b0;
      cmd_byte     = 8'h00;
      errs         = 0;
      checks       = 0;
      for (int i = 0; i < 4*1024*1024; i++) begin
         lo                 = fill_byte(23'(2 * i));
         hi                 = fill_byte(23'(2 * i + 1));
         sram_mem[i]        = {hi, lo};
         ref_mem[2 * i]     = lo;
         ref_mem[2 * i + 1] = hi;
      end
      cur_mapper    = 1'b0;
      cur_rom_mask  = `CART_ROM_MASK_RST;
      cur_save_mask = `CART_SAVE_MASK_RST;
      host_ptr      = 24'h00_0000;
      repeat (2) @(posedge clk2);
      rst_n <= 1'b1;

      // idle state after reset
      start_test();
      @(negedge clk2);
      check_byte("reset_ctrl", 8'h0f, {4'd0, sram_oe_n, sram_we_n, sram_bhe_n, sram_ble_n});
      check_byte("reset_ce", 8'h0f, {4'd0, sram_ce_n});
      check_byte("reset_oe", 8'h00, {6'd0, sram_data_oe, snes_data_oe});
      check_byte("reset_busy", 8'h00, {7'd0, host_busy});
      end_test("reset");

      // host streams of 4 bytes over both lanes
      start_test();
      for (int g = 0; g < 6; g++) begin
         r       = next_rand();
         base[g] = r[23:0];
         set_host_addr(base[g]);
         strobe_cmd(8'h90);
         repeat (4) begin
            r = next_rand();
            host_write(r[7:0]);
         end
      end
      for (int g = 0; g < 6; g++) begin
         set_host_addr(base[g]);
         strobe_cmd(8'h80);
         repeat (4) host_read_check("host_rw");
      end
      end_test("host_rw");

      // hirom load then snes reads
      start_test();
      set_mapper(1'b0);
      r = next_rand();
      k = 17 + (r % 6);                      // 128K to 4M rom
      set_rom_mask((24'd1 << k) - 24'd1);
      r = next_rand();
      a = r[23:0] & cur_rom_mask & 24'hff_fff0;
      set_host_addr(a);
      strobe_cmd(8'h90);
      repeat (16) begin
         r = next_rand();
         host_write(r[7:0]);
      end
      for (int i = 0; i < 16; i++) begin
         r = next_rand();
         if (i % 2 == 0)
            sa = 24'hc0_0000 | (a + {20'd0, r[3:0]});   // hits the loaded bytes
         else if (r[31])
            sa = r[23:0] | 24'h40_0000;
         else
            sa = r[23:0] | 24'h00_8000;
         snes_read_check("hirom_read", sa);
      end
      end_test("hirom_read");

      // lorom save writes land and rom writes do not
      start_test();
      set_mapper(1'b1);
      for (int i = 0; i < 3; i++) begin
         r  = next_rand();
         sa = {4'h7, 4'(r[19:16] % 14), 1'b0, r[14:0]};   // banks 70 to 7d
         snes_write(sa, r[31:24]);
         a = map_snes(sa, sv, rm);
         set_host_addr(a);
         strobe_cmd(8'h80);
         host_read_check("lorom_save");
      end
      for (int i = 0; i < 2; i++) begin
         r  = next_rand();
         sa = r[23:0] | 24'h00_8000;
         a  = map_snes(sa, sv, rm);
         snes_write(sa, ~ref_mem[a[22:0]]);
         set_host_addr(a);
         strobe_cmd(8'h80);
         host_read_check("lorom_rom_wp");
      end
      end_test("lorom_write");

      // host stream into save area while the snes reads rom
      start_test();
      r = next_rand();
      a = {3'b011, r[20:4], 4'h0};
      for (int j = 0; j < 16; j++) begin   // stream bytes for the host side
         rh        = next_rand();
         hbytes[j] = rh[7:0];
      end
      fork
         begin
            set_host_addr(a);
            strobe_cmd(8'h90);
            for (int j = 0; j < 16; j++)
               host_write(hbytes[j]);
         end
         begin
            repeat (12) begin
               rs = next_rand();
               snes_read_check("mixed_snes", rs[23:0] | 24'h00_8000);
            end
         end
      join
      set_host_addr(a);
      strobe_cmd(8'h80);
      repeat (16) host_read_check("mixed_host");
      end_test("mixed");

      $display("5 tests, %0d checks, %0d errors", checks, errs);
      if (errs == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/cart_pkg.sv
hdl/host_if.sv
hdl/host_regs.sv
hdl/addr_map.sv
hdl/cycle_seq.sv
hdl/data_path.sv
hdl/cart_top.sv
testbench/tb_cart.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cartridge controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sources.f \
   --top-module tb_cart \
   -o tb_cart

./obj_dir/tb_cart | tee sim.log

# pass only if the testbench reported it
grep -q "TESTS PASSED" sim.log
